// ==== bpu_top.f ====
+incdir+testbench
common/bpu_isa_pkg.sv
common/bpu_cfg_pkg.sv
predictor/pred_table.sv
predictor/direction_predictor.sv
predictor/target_buffer.sv
rtl/inst_predecode.sv
rtl/table_init_fsm.sv
rtl/return_stack.sv
rtl/next_pc_select.sv
rtl/bpu_top.sv
testbench/tb_bpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f bpu_top.f --top-module tb_bpu_top -o sim_bpu
status=0
./obj_dir/sim_bpu > sim.log 2>&1 || status=$?
cat sim.log
if grep -qx "Verification passed" sim.log; then
    exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1

// ==== testbench/tb_stim_table.svh ====
localparam int n_rows = 23;

localparam logic [31:0] p1 = 32'h0000_1000;   // trained branch
localparam logic [31:0] p2 = 32'h0000_2040;   // jal site
localparam logic [31:0] p3 = 32'h0000_3080;   // return site
localparam logic [31:0] p4 = 32'h0000_2104;   // untouched counter and btb slot
localparam logic [31:0] t1 = 32'h0000_1800;
localparam logic [31:0] t2 = 32'h0000_7000;
localparam logic [31:0] a1 = 32'h0000_4004;
localparam logic [31:0] a2 = 32'h0000_5008;
localparam logic [31:0] a3 = 32'h0000_600c;

localparam logic [31:0] nop     = 32'h0000_0013;   // addi x0, x0, 0
localparam logic [31:0] beq_f   = 32'h0000_0863;   // beq x0, x0, +16
localparam logic [31:0] beq_b   = 32'hfe00_0ce3;   // beq x0, x0, -8
localparam logic [31:0] jal_ra  = 32'h1000_00ef;   // jal ra, +256
localparam logic [31:0] jalr_x6 = 32'h0003_00e7;   // jalr ra, 0(x6)
localparam logic [31:0] ret_ra  = 32'h0000_8067;   // jalr x0, 0(ra)

stim_row_t stim [n_rows];

// columns: fetch pc, fetch inst, ex {valid,taken}, ex pc, ex target, ex inst,
// push {valid,stall}, push addr, random tag, mask {pred,hist}, expected {branch,taken}
task automatic fill_stim_table();
    stim[0]  = '{p1, nop,     2'b00, 32'h0, 32'h0, nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b00};
    stim[1]  = '{p1, beq_f,   2'b11, p1,    t1,    nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b10};
    stim[2]  = '{p1, beq_f,   2'b11, p1,    t1,    nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[3]  = '{p1, beq_f,   2'b11, p1,    t1,    nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[4]  = '{p1, beq_f,   2'b11, p1,    t1,    nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[5]  = '{p1, beq_f,   2'b10, p1,    t1,    nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[6]  = '{p1, beq_f,   2'b10, p1,    t1,    nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[7]  = '{p1, beq_f,   2'b00, 32'h0, 32'h0, nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b10};
    stim[8]  = '{p1, jal_ra,  2'b11, p1,    t1,    nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[9]  = '{p1, beq_b,   2'b00, 32'h0, 32'h0, nop,    2'b00, 32'h0, 1'b1, 2'b11, 2'b11};
    stim[10] = '{p2, jal_ra,  2'b11, p2,    t2,    nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[11] = '{p2, jal_ra,  2'b00, 32'h0, 32'h0, nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[12] = '{p2, jalr_x6, 2'b00, 32'h0, 32'h0, nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[13] = '{p4, jalr_x6, 2'b00, 32'h0, 32'h0, nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b10};
    stim[14] = '{p3, ret_ra,  2'b00, 32'h0, 32'h0, nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b10};
    stim[15] = '{p3, ret_ra,  2'b00, 32'h0, 32'h0, nop,    2'b10, a1,    1'b0, 2'b11, 2'b11};
    stim[16] = '{p3, nop,     2'b00, 32'h0, 32'h0, nop,    2'b10, a2,    1'b0, 2'b11, 2'b00};
    stim[17] = '{p3, ret_ra,  2'b00, 32'h0, 32'h0, nop,    2'b11, a3,    1'b0, 2'b11, 2'b11};
    stim[18] = '{p3, ret_ra,  2'b11, p3,    a2,    ret_ra, 2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[19] = '{p3, ret_ra,  2'b11, p3,    a1,    ret_ra, 2'b00, 32'h0, 1'b0, 2'b11, 2'b11};
    stim[20] = '{p3, ret_ra,  2'b00, 32'h0, 32'h0, nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b10};
    stim[21] = '{p3, ret_ra,  2'b00, 32'h0, 32'h0, nop,    2'b11, a3,    1'b0, 2'b11, 2'b10};
    stim[22] = '{p3, ret_ra,  2'b00, 32'h0, 32'h0, nop,    2'b00, 32'h0, 1'b0, 2'b11, 2'b10};
endtask

// ==== testbench/tb_bpu_top.sv ====
`timescale 1ns/10ps

module tb_bpu_top;

    typedef struct packed {
        logic [31:0] if_pc;
        logic [31:0] if_inst;
        logic [1:0]  ex;          // valid, taken
        logic [31:0] ex_pc;
        logic [31:0] ex_target;
        logic [31:0] ex_inst;
        logic [1:0]  push;        // valid, stall
        logic [31:0] push_data;
        logic        rnd_tag;     // swap in random low tag bits
        logic [1:0]  mask;        // check prediction, check history
        logic [1:0]  exp_bt;      // expected branch, taken
    } stim_row_t;

    logic        clk;
    logic        rst;
    logic [31:0] if_pc;
    logic [31:0] if_inst;
    logic        ex_valid;
    logic        ex_taken;
    logic [31:0] ex_pc;
    logic [31:0] ex_target;
    logic [31:0] ex_inst;
    logic        push_valid;
    logic [31:0] push_data;
    logic        stall;
    logic        branch;
    logic        pred_taken;
    logic [31:0] pred_pc;
    logic [15:0] history;
    logic        ready;

    // reference model state
    logic [1:0]  m_ctr [512];
    logic        m_btb_valid [256];
    logic [21:0] m_btb_tag [256];
    logic [31:0] m_btb_target [256];
    logic [31:0] m_stack [$];
    logic [15:0] m_hist;
    logic [31:0] lfsr_state;

    `include "tb_stim_table.svh"

    bpu_top bpu_top_i (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc),
        .if_inst_i           (if_inst),
        .ex_branch_valid_i   (ex_valid),
        .ex_branch_taken_i   (ex_taken),
        .ex_pc_i             (ex_pc),
        .ex_target_i         (ex_target),
        .ex_inst_i           (ex_inst),
        .id_ras_push_valid_i (push_valid),
        .id_ras_push_data_i  (push_data),
        .ex_stall_valid_i    (stall),
        .branch_o            (branch),
        .pred_taken_o        (pred_taken),
        .pred_pc_o           (pred_pc),
        .history_o           (history),
        .ready_o             (ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : watchdog
        #((4 + 512 + n_rows + 20) * 40);
        $display("timeout: the run did not reach its end in time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b[i] = lfsr_state[0];   // one step per bit
        end
    endtask

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, actual,
                     expected);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < 512; i++) m_ctr[i] = 2'd1;   // weakly not taken
        for (int i = 0; i < 256; i++) m_btb_valid[i] = 1'b0;
        m_stack.delete();
        m_hist = '0;
    endtask

    task automatic model_predict(input logic [31:0] pc, input logic [31:0] inst,
                                 input logic push_eff, input logic [31:0] push_d,
                                 output logic [31:0] npc);
        logic [6:0]  opc;
        logic [7:0]  bi;
        logic        hit;
        logic        ret_form;
        logic [31:0] b_off;
        logic [31:0] j_off;
        opc = inst[6:0];
        bi = pc[9:2];
        hit = m_btb_valid[bi] && (m_btb_tag[bi] == pc[31:10]);
        b_off = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        j_off = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        ret_form = (opc == 7'h67) && (inst[11:7] == 5'd0) && (inst[31:20] == 12'd0) &&
                   (inst[19:15] == 5'd1 || inst[19:15] == 5'd5);
        npc = pc + 32'd4;
        if (ret_form) begin
            if (m_stack.size() > 0) npc = m_stack[$];
            else if (push_eff) npc = push_d;   // same-cycle call
        end else if (opc == 7'h6f) begin
            npc = hit ? m_btb_target[bi] : pc + j_off;
        end else if ((opc == 7'h63 || opc == 7'h67) && m_ctr[pc[9:1]][1]) begin
            if (hit) npc = m_btb_target[bi];
            else if (opc == 7'h63) npc = pc + b_off;
        end
    endtask

    task automatic model_update(input stim_row_t row);
        logic [8:0] ci;
        logic [7:0] bi;
        logic       pop_ret;
        ci = row.ex_pc[9:1];
        bi = row.ex_pc[9:2];
        if (row.ex[1]) begin
            if (row.ex[0] && m_ctr[ci] != 2'd3) m_ctr[ci] = m_ctr[ci] + 2'd1;
            else if (!row.ex[0] && m_ctr[ci] != 2'd0) m_ctr[ci] = m_ctr[ci] - 2'd1;
            if (row.ex[0]) begin
                m_btb_valid[bi] = 1'b1;
                m_btb_tag[bi] = row.ex_pc[31:10];
                m_btb_target[bi] = row.ex_target;
            end
            m_hist = {m_hist[14:0], row.ex[0]};
        end
        pop_ret = (row.ex == 2'b11) && (row.ex_inst[6:0] == 7'h67) && !row.push[0] &&
                  (row.ex_inst[19:15] == 5'd1 || row.ex_inst[19:15] == 5'd5);
        if (pop_ret && m_stack.size() > 0) void'(m_stack.pop_back());   // pop before push
        if (row.push == 2'b10 && m_stack.size() < 32) m_stack.push_back(row.push_data);
    endtask

    initial begin : stimulus
        int          cycles;
        stim_row_t   row;
        logic [7:0]  rb;
        logic [31:0] exp_pc;
        rst <= 1'b1;
        if_pc <= '0;
        if_inst <= '0;
        ex_valid <= 1'b0;
        ex_taken <= 1'b0;
        ex_pc <= '0;
        ex_target <= '0;
        ex_inst <= '0;
        push_valid <= 1'b0;
        push_data <= '0;
        stall <= 1'b0;
        lfsr_state = 32'h73a0a081;
        fill_stim_table();
        model_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare("ready_o", 32'(ready), 32'd0);   // held low in reset
        @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!ready) begin
            cycles++;
            @(negedge clk);
        end
        compare("sweep cycles", 32'(cycles), 32'd512);
        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            row = stim[r];
            if (row.rnd_tag) begin
                take_random_byte(rb);
                row.if_pc = row.if_pc ^ {14'h0, rb | 8'h01, 10'h0};   // same index, new tag
            end
            if_pc <= row.if_pc;
            if_inst <= row.if_inst;
            ex_valid <= row.ex[1];
            ex_taken <= row.ex[0];
            ex_pc <= row.ex_pc;
            ex_target <= row.ex_target;
            ex_inst <= row.ex_inst;
            push_valid <= row.push[1];
            push_data <= row.push_data;
            stall <= row.push[0];
            @(negedge clk);
            model_predict(row.if_pc, row.if_inst, row.push == 2'b10, row.push_data, exp_pc);
            if (row.mask[1]) begin
                compare("branch_o", 32'(branch), 32'(row.exp_bt[1]));
                compare("pred_taken_o", 32'(pred_taken), 32'(row.exp_bt[0]));
                compare("pred_pc_o", pred_pc, exp_pc);
            end
            if (row.mask[0]) compare("history_o", 32'(history), 32'(m_hist));
            model_update(row);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== rtl/bpu_top.sv ====
`timescale 1ns/10ps

module bpu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  bpu_isa_pkg::addr_t             if_pc_i,
    input  bpu_isa_pkg::inst_t             if_inst_i,
    input  logic                           ex_branch_valid_i,
    input  logic                           ex_branch_taken_i,
    input  bpu_isa_pkg::addr_t             ex_pc_i,
    input  bpu_isa_pkg::addr_t             ex_target_i,
    input  bpu_isa_pkg::inst_t             ex_inst_i,
    input  logic                           id_ras_push_valid_i,
    input  bpu_isa_pkg::addr_t             id_ras_push_data_i,
    input  logic                           ex_stall_valid_i,
    output logic                           branch_o,
    output logic                           pred_taken_o,
    output bpu_isa_pkg::addr_t             pred_pc_o,
    output logic [bpu_cfg_pkg::hist_w-1:0] history_o,
    output logic                           ready_o
);
    import bpu_isa_pkg::*;
    import bpu_cfg_pkg::*;

    logic               sweep_en;
    logic [sweep_w-1:0] sweep_idx;
    logic               ready;
    logic               is_branch;
    logic               is_jal;
    logic               is_jalr;
    logic               is_ret;
    logic               ex_is_ret;
    addr_t              b_imm;
    addr_t              j_imm;
    logic               ctr_taken;
    logic               btb_hit;
    addr_t              btb_target;
    logic               ras_valid;
    addr_t              ras_addr;
    logic               upd_en;
    logic               ras_push;
    logic               ras_pop;

    // stall only holds the stack, tables and history still train
    assign upd_en   = ex_branch_valid_i && ready;
    assign ras_push = id_ras_push_valid_i && !ex_stall_valid_i && ready;
    assign ras_pop  = ex_branch_valid_i && ex_branch_taken_i && ex_is_ret &&
                      !ex_stall_valid_i;

    table_init_fsm init_fsm_i (
        .clk         (clk),
        .rst         (rst),
        .sweep_en_o  (sweep_en),
        .sweep_idx_o (sweep_idx),
        .ready_o     (ready)
    );

    inst_predecode predecode_i (
        .if_inst_i   (if_inst_i),
        .ex_inst_i   (ex_inst_i),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_ret_o    (is_ret),
        .ex_is_ret_o (ex_is_ret),
        .b_imm_o     (b_imm),
        .j_imm_o     (j_imm)
    );

    direction_predictor #(
        .HIST_W (hist_w)
    ) dir_pred_i (
        .clk          (clk),
        .rst          (rst),
        .if_pc_i      (if_pc_i),
        .upd_en_i     (upd_en),
        .upd_pc_i     (ex_pc_i),
        .upd_taken_i  (ex_branch_taken_i),
        .sweep_en_i   (sweep_en),
        .sweep_idx_i  (sweep_idx),
        .pred_taken_o (ctr_taken),
        .history_o    (history_o)
    );

    target_buffer btb_i (
        .clk          (clk),
        .if_pc_i      (if_pc_i),
        .upd_en_i     (upd_en),
        .upd_pc_i     (ex_pc_i),
        .upd_taken_i  (ex_branch_taken_i),
        .upd_target_i (ex_target_i),
        .sweep_en_i   (sweep_en),
        .sweep_idx_i  (sweep_idx),
        .btb_hit_o    (btb_hit),
        .btb_target_o (btb_target)
    );

    return_stack #(
        .RAS_DEPTH (ras_depth)
    ) ras_i (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push),
        .push_addr_i (id_ras_push_data_i),
        .pop_i       (ras_pop),
        .top_valid_o (ras_valid),
        .top_addr_o  (ras_addr)
    );

    next_pc_select npc_sel_i (
        .if_pc_i      (if_pc_i),
        .is_branch_i  (is_branch),
        .is_jal_i     (is_jal),
        .is_jalr_i    (is_jalr),
        .is_ret_i     (is_ret),
        .b_imm_i      (b_imm),
        .j_imm_i      (j_imm),
        .ready_i      (ready),
        .ctr_taken_i  (ctr_taken),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .ras_valid_i  (ras_valid),
        .ras_addr_i   (ras_addr),
        .push_valid_i (ras_push),
        .push_addr_i  (id_ras_push_data_i),
        .branch_o     (branch_o),
        .pred_taken_o (pred_taken_o),
        .pred_pc_o    (pred_pc_o)
    );

    assign ready_o = ready;

endmodule

// ==== rtl/next_pc_select.sv ====
`timescale 1ns/10ps

module next_pc_select (
    input  bpu_isa_pkg::addr_t if_pc_i,
    input  logic               is_branch_i,
    input  logic               is_jal_i,
    input  logic               is_jalr_i,
    input  logic               is_ret_i,
    input  bpu_isa_pkg::addr_t b_imm_i,
    input  bpu_isa_pkg::addr_t j_imm_i,
    input  logic               ready_i,
    input  logic               ctr_taken_i,
    input  logic               btb_hit_i,
    input  bpu_isa_pkg::addr_t btb_target_i,
    input  logic               ras_valid_i,
    input  bpu_isa_pkg::addr_t ras_addr_i,
    input  logic               push_valid_i,
    input  bpu_isa_pkg::addr_t push_addr_i,
    output logic               branch_o,
    output logic               pred_taken_o,
    output bpu_isa_pkg::addr_t pred_pc_o
);
    import bpu_isa_pkg::*;

    addr_t pc_plus4;

    assign pc_plus4 = if_pc_i + xlen'(4);

    always_comb begin
        branch_o     = 1'b0;
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_plus4;
        if (ready_i && (is_branch_i || is_jal_i || is_jalr_i)) begin
            branch_o = 1'b1;
            if (is_ret_i) begin
                if (ras_valid_i) begin
                    pred_taken_o = 1'b1;
                    pred_pc_o    = ras_addr_i;
                end else if (push_valid_i) begin   // empty stack, bypass the call
                    pred_taken_o = 1'b1;
                    pred_pc_o    = push_addr_i;
                end
            end else if (is_jal_i) begin
                pred_taken_o = 1'b1;
                pred_pc_o    = btb_hit_i ? btb_target_i : if_pc_i + j_imm_i;
            end else begin
                pred_taken_o = ctr_taken_i;
                if (ctr_taken_i) begin
                    if (btb_hit_i) begin
                        pred_pc_o = btb_target_i;
                    end else if (is_branch_i) begin
                        pred_pc_o = if_pc_i + b_imm_i;
                    end   // plain jalr without a btb entry keeps pc+4
                end
            end
        end
    end

endmodule

// ==== rtl/return_stack.sv ====
`timescale 1ns/10ps

module return_stack #(
    parameter int RAS_DEPTH = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               push_i,
    input  bpu_isa_pkg::addr_t push_addr_i,
    input  logic               pop_i,
    output logic               top_valid_o,
    output bpu_isa_pkg::addr_t top_addr_o
);
    import bpu_isa_pkg::*;

    localparam int PTR_W = $clog2(RAS_DEPTH + 1);   // needs to reach RAS_DEPTH
    localparam int IDX_W = $clog2(RAS_DEPTH);

    addr_t            stack_mem [RAS_DEPTH];
    logic [PTR_W-1:0] sp;          // next free slot
    logic [PTR_W-1:0] sp_popped;
    logic [PTR_W-1:0] sp_top;
    logic             pop_ok;
    logic             push_ok;

    // pop first, so a push in the same cycle lands in the freed slot
    assign pop_ok    = pop_i && (sp != '0);
    assign sp_popped = pop_ok ? sp - 1'b1 : sp;
    assign push_ok   = push_i && (sp_popped < PTR_W'(RAS_DEPTH));   // full: drop it

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= '0;
        end else begin
            sp <= push_ok ? sp_popped + 1'b1 : sp_popped;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            stack_mem[sp_popped[IDX_W-1:0]] <= push_addr_i;
        end
    end

    assign sp_top      = sp - 1'b1;
    assign top_valid_o = (sp != '0);
    assign top_addr_o  = stack_mem[sp_top[IDX_W-1:0]];   // don't care when empty

endmodule

// ==== rtl/table_init_fsm.sv ====
`timescale 1ns/10ps

module table_init_fsm (
    input  logic                          clk,
    input  logic                          rst,
    output logic                          sweep_en_o,
    output logic [bpu_cfg_pkg::sweep_w-1:0] sweep_idx_o,
    output logic                          ready_o
);
    import bpu_cfg_pkg::*;

    typedef enum logic {
        st_sweep,
        st_run
    } state_t;

    state_t             state;
    logic [sweep_w-1:0] idx;
    logic               last_idx;

    assign last_idx = (idx == sweep_w'(bimodal_entries - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_sweep;
            idx   <= '0;
        end else begin
            case (state)
                st_sweep: begin
                    idx <= idx + 1'b1;
                    if (last_idx) begin
                        state <= st_run;   // one write per entry, then done
                    end
                end
                default: begin
                    state <= st_run;   // stays here until the next reset
                end
            endcase
        end
    end

    assign sweep_en_o  = (state == st_sweep);
    assign sweep_idx_o = idx;
    assign ready_o     = (state == st_run);

endmodule

// ==== rtl/inst_predecode.sv ====
`timescale 1ns/10ps

module inst_predecode (
    input  bpu_isa_pkg::inst_t if_inst_i,
    input  bpu_isa_pkg::inst_t ex_inst_i,
    output logic               is_branch_o,
    output logic               is_jal_o,
    output logic               is_jalr_o,
    output logic               is_ret_o,
    output logic               ex_is_ret_o,
    output bpu_isa_pkg::addr_t b_imm_o,
    output bpu_isa_pkg::addr_t j_imm_o
);
    import bpu_isa_pkg::*;

    logic if_rs1_link;
    logic ex_rs1_link;

    assign is_branch_o = (if_inst_i[6:0] == opcode_branch);
    assign is_jal_o    = (if_inst_i[6:0] == opcode_jal);
    assign is_jalr_o   = (if_inst_i[6:0] == opcode_jalr);

    assign if_rs1_link = (if_inst_i[19:15] == reg_ra) || (if_inst_i[19:15] == reg_t0);
    assign ex_rs1_link = (ex_inst_i[19:15] == reg_ra) || (ex_inst_i[19:15] == reg_t0);

    // fetch side: strict "jalr x0, 0(ra)" form
    assign is_ret_o = is_jalr_o && (if_inst_i[11:7] == 5'd0) && if_rs1_link &&
                      (if_inst_i[31:20] == 12'd0);

    // execute side only looks at opcode and rs1
    assign ex_is_ret_o = (ex_inst_i[6:0] == opcode_jalr) && ex_rs1_link;

    assign b_imm_o = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                      if_inst_i[11:8], 1'b0};
    assign j_imm_o = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                      if_inst_i[30:21], 1'b0};

endmodule

// ==== predictor/target_buffer.sv ====
`timescale 1ns/10ps

module target_buffer (
    input  logic                            clk,
    input  bpu_isa_pkg::addr_t              if_pc_i,
    input  logic                            upd_en_i,
    input  bpu_isa_pkg::addr_t              upd_pc_i,
    input  logic                            upd_taken_i,
    input  bpu_isa_pkg::addr_t              upd_target_i,
    input  logic                            sweep_en_i,
    input  logic [bpu_cfg_pkg::sweep_w-1:0] sweep_idx_i,
    output logic                            btb_hit_o,
    output bpu_isa_pkg::addr_t              btb_target_o
);
    import bpu_isa_pkg::*;
    import bpu_cfg_pkg::*;

    logic [btb_idx_w-1:0] fetch_idx;
    logic [btb_tag_w-1:0] fetch_tag;
    logic [btb_idx_w-1:0] upd_idx;
    btb_entry_t           rd_entry;
    btb_entry_t           upd_entry;
    btb_entry_t           sweep_entry;

    assign fetch_idx = if_pc_i[btb_idx_w+1:2];
    assign fetch_tag = if_pc_i[xlen-1:xlen-btb_tag_w];
    assign upd_idx   = upd_pc_i[btb_idx_w+1:2];

    // only taken branches allocate, existing entry is simply replaced
    assign upd_entry.valid  = 1'b1;
    assign upd_entry.tag    = upd_pc_i[xlen-1:xlen-btb_tag_w];
    assign upd_entry.target = upd_target_i;

    assign sweep_entry = '0;   // valid cleared

    pred_table #(
        .ENTRIES (btb_entries),
        .entry_t (btb_entry_t)
    ) btb_tbl_i (
        .clk          (clk),
        .rd_idx_i     (fetch_idx),
        .rd_data_o    (rd_entry),
        .wr_en_i      (upd_en_i && upd_taken_i),
        .wr_idx_i     (upd_idx),
        .wr_data_i    (upd_entry),
        .sweep_en_i   (sweep_en_i),
        .sweep_idx_i  (sweep_idx_i[btb_idx_w-1:0]),   // smaller table, low bits only
        .sweep_data_i (sweep_entry)
    );

    assign btb_hit_o    = rd_entry.valid && (rd_entry.tag == fetch_tag);
    assign btb_target_o = rd_entry.target;

endmodule

// ==== predictor/direction_predictor.sv ====
`timescale 1ns/10ps

module direction_predictor #(
    parameter int HIST_W = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  bpu_isa_pkg::addr_t              if_pc_i,
    input  logic                            upd_en_i,
    input  bpu_isa_pkg::addr_t              upd_pc_i,
    input  logic                            upd_taken_i,
    input  logic                            sweep_en_i,
    input  logic [bpu_cfg_pkg::sweep_w-1:0] sweep_idx_i,
    output logic                            pred_taken_o,
    output logic [HIST_W-1:0]               history_o
);
    import bpu_cfg_pkg::*;

    logic [bimodal_idx_w-1:0] fetch_idx;
    logic [bimodal_idx_w-1:0] upd_idx;
    ctr_t                     fetch_ctr;
    ctr_t                     upd_ctr;
    ctr_t                     upd_ctr_next;
    logic [HIST_W-1:0]        ghist;

    assign fetch_idx = if_pc_i[bimodal_idx_w:1];
    assign upd_idx   = upd_pc_i[bimodal_idx_w:1];

    always_comb begin
        if (upd_taken_i) begin
            upd_ctr_next = (upd_ctr == 2'b11) ? upd_ctr : upd_ctr + 1'b1;
        end else begin
            upd_ctr_next = (upd_ctr == 2'b00) ? upd_ctr : upd_ctr - 1'b1;
        end
    end

    // two copies written identically, one read port each
    pred_table #(
        .ENTRIES (bimodal_entries),
        .entry_t (ctr_t)
    ) fetch_tbl_i (
        .clk          (clk),
        .rd_idx_i     (fetch_idx),
        .rd_data_o    (fetch_ctr),
        .wr_en_i      (upd_en_i),
        .wr_idx_i     (upd_idx),
        .wr_data_i    (upd_ctr_next),
        .sweep_en_i   (sweep_en_i),
        .sweep_idx_i  (sweep_idx_i),
        .sweep_data_i (ctr_weak_nt)
    );

    pred_table #(
        .ENTRIES (bimodal_entries),
        .entry_t (ctr_t)
    ) upd_tbl_i (
        .clk          (clk),
        .rd_idx_i     (upd_idx),   // read-modify-write side
        .rd_data_o    (upd_ctr),
        .wr_en_i      (upd_en_i),
        .wr_idx_i     (upd_idx),
        .wr_data_i    (upd_ctr_next),
        .sweep_en_i   (sweep_en_i),
        .sweep_idx_i  (sweep_idx_i),
        .sweep_data_i (ctr_weak_nt)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
        end else if (upd_en_i) begin
            ghist <= {ghist[HIST_W-2:0], upd_taken_i};   // newest in bit 0
        end
    end

    assign pred_taken_o = fetch_ctr[1];
    assign history_o    = ghist;

endmodule

// ==== predictor/pred_table.sv ====
`timescale 1ns/10ps

module pred_table #(
    parameter int  ENTRIES = 512,
    parameter type entry_t = logic
) (
    input  logic                       clk,
    input  logic [$clog2(ENTRIES)-1:0] rd_idx_i,
    output entry_t                     rd_data_o,
    input  logic                       wr_en_i,
    input  logic [$clog2(ENTRIES)-1:0] wr_idx_i,
    input  entry_t                     wr_data_i,
    input  logic                       sweep_en_i,
    input  logic [$clog2(ENTRIES)-1:0] sweep_idx_i,
    input  entry_t                     sweep_data_i
);

    entry_t mem [ENTRIES];

    always_ff @(posedge clk) begin
        if (sweep_en_i) begin
            mem[sweep_idx_i] <= sweep_data_i;   // init sweep wins
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    assign rd_data_o = mem[rd_idx_i];   // async read for same-cycle prediction

endmodule

// ==== common/bpu_cfg_pkg.sv ====
package bpu_cfg_pkg;

    // bimodal direction table, indexed by pc[9:1]
    localparam int bimodal_entries = 512;
    localparam int bimodal_idx_w   = 9;

    // direct mapped btb, index pc[9:2], tag pc[31:10]
    localparam int btb_entries = 256;
    localparam int btb_idx_w   = 8;
    localparam int btb_tag_w   = 22;

    localparam int ras_depth = 32;
    localparam int ras_ptr_w = 6;   // 0..32 inclusive

    localparam int hist_w = 16;

    // init sweep walks the larger of the two tables
    localparam int sweep_w = 9;

    typedef logic [1:0] ctr_t;   // 2-bit saturating counter

    localparam ctr_t ctr_weak_nt = 2'b01;

    typedef struct packed {
        logic                   valid;
        logic [btb_tag_w-1:0]   tag;
        bpu_isa_pkg::addr_t     target;
    } btb_entry_t;   // 1 + 22 + 32 = 55 bits

endpackage

// ==== common/bpu_isa_pkg.sv ====
package bpu_isa_pkg;

    // rv32 word size, used for both pc and instruction
    localparam int xlen = 32;

    // major opcodes seen by predecode
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;

    // link registers, a jalr through one of these is treated as a return
    localparam logic [4:0] reg_ra = 5'd1;
    localparam logic [4:0] reg_t0 = 5'd5;

    typedef logic [xlen-1:0] addr_t;
    typedef logic [xlen-1:0] inst_t;

endpackage
